// File: verification/ulpi_link_stim.txt
# op f0..f5 in hex. P power-on, R rxcmd vbus squelch eop, H rxcmd cycles reset suspend idle
# D count bytes, B count bytes with rx_ready low, T count pid_byte data bytes
P 0 0 0 0 0 0
R 0d 1 0 0 0 0
R 0c 1 1 1 0 0
R 0c 1 1 0 0 0
R 02 0 0 0 0 0
R 0e 1 0 0 0 0
D 3 a5 5a 3c 0 0
D 1 7e 0 0 0 0
D 5 01 02 03 04 05
T 4 c3 11 22 33 0
T 1 d2 0 0 0 0
T 5 e1 80 00 ff 42
B 4 10 20 30 40 0
H 0c 32 1 0 0 0
H 0e 4 0 0 1 0
H 0d 46 0 1 0 0
H 0e 4 0 0 1 0
T 2 c9 55 0 0 0

// File: filelist.f
hw/ulpi_pkg.sv
hw/ulpi_rxcmd_decode.sv
hw/ulpi_rx_capture.sv
hw/ulpi_tx_buffer.sv
hw/ulpi_link_fsm.sv
hw/ulpi_link_top.sv
verification/ulpi_link_chk.sv
verification/ulpi_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= ulpi_link_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert -Wno-fatal
PASS_MSG ?= All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ulpi_link_tb.sv
`timescale 1ns/1ps

module ulpi_link_tb;

  logic            ulpi_clk;
  logic            rst_n;
  ulpi_pkg::byte_t ulpi_data_i;
  ulpi_pkg::byte_t ulpi_data_o;
  logic            ulpi_dir_i;
  logic            ulpi_nxt_i;
  logic            ulpi_stp_o;
  logic            rx_valid_o;
  logic            rx_ready_i;
  logic            rx_last_o;
  ulpi_pkg::byte_t rx_data_o;
  logic            tx_valid_i;
  logic            tx_ready_o;
  logic            tx_last_i;
  ulpi_pkg::byte_t tx_data_i;
  logic            rx_overflow_o;
  logic            vbus_valid_o;
  logic            squelch_o;
  logic            eop_o;
  logic            usb_reset_o;
  logic            usb_idle_o;
  logic            usb_suspend_o;

  integer          seed = 94714;
  int              cycles = 0;
  int              limit = 0;
  int              errors = 0;
  bit              done = 1'b0;
  bit              reported = 1'b0;
  bit              stp_seen = 1'b0;
  string           op_q[$];
  int              arg_q[$];
  ulpi_pkg::byte_t rx_seen_q[$];
  logic            last_seen_q[$];

  ulpi_link_top dut0 (.*);

  bind ulpi_link_top ulpi_link_chk chk0 (
    .ulpi_clk(ulpi_clk), .rst_n(rst_n), .ulpi_dir_i(ulpi_dir_i), .link_data_i(ulpi_data_o),
    .stp_i(ulpi_stp_o), .stop_req_i(rx_stop_req), .rx_valid_i(rx_valid_o),
    .rx_last_i(rx_last_o)
  );

  initial begin
    ulpi_clk = 1'b0;
    forever #2 ulpi_clk = ~ulpi_clk;
  end

  always @(posedge ulpi_clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles > limit && !done) begin
      reported = 1'b1;
      $display("Run did not finish within %0d cycles", limit);
      $display("Test failures found");
      $fatal(1, "Timeout");
    end
  end

  // RX stream and STP monitor
  always @(negedge ulpi_clk) begin
    if (rx_valid_o) begin
      rx_seen_q.push_back(rx_data_o);
      last_seen_q.push_back(rx_last_o);
    end
    if (ulpi_stp_o && ulpi_dir_i) stp_seen = 1'b1;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      reported = 1'b1;
      $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("Test failures found");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // PHY side of a link write, nxt after a random gap
  task automatic phy_accept(input ulpi_pkg::byte_t exp_q[$]);
    int gap;
    @(negedge ulpi_clk);
    while (ulpi_data_o == 8'h00) @(negedge ulpi_clk);
    foreach (exp_q[i]) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge ulpi_clk);
      check("ulpi_data_o", ulpi_data_o, exp_q[i]);
      @(posedge ulpi_clk) ulpi_nxt_i <= 1'b1;
      @(posedge ulpi_clk) ulpi_nxt_i <= 1'b0;
      @(negedge ulpi_clk);
    end
    check("ulpi_stp_o", ulpi_stp_o, 1);
    check("tx_ready_o", tx_ready_o, 0);
    @(negedge ulpi_clk);
    check("ulpi_stp_o", ulpi_stp_o, 0);
    check("usb_idle_o", usb_idle_o, 1);
  endtask

  task automatic stream_send(input ulpi_pkg::byte_t b_q[$]);
    bit fire;
    foreach (b_q[i]) begin
      tx_valid_i <= 1'b1;
      tx_data_i <= b_q[i];
      tx_last_i <= i == b_q.size() - 1;
      do begin
        @(negedge ulpi_clk);
        fire = tx_ready_o;
        @(posedge ulpi_clk);
      end while (!fire);
    end
    tx_valid_i <= 1'b0;
    tx_last_i <= 1'b0;
  endtask

  task automatic send_rxcmd(input ulpi_pkg::byte_t cmd);
    @(posedge ulpi_clk);
    ulpi_dir_i <= 1'b1;   // Turnaround first
    ulpi_nxt_i <= 1'b0;
    ulpi_data_i <= cmd;
    @(posedge ulpi_clk);
    @(posedge ulpi_clk);
    ulpi_dir_i <= 1'b0;
    ulpi_data_i <= 8'h00;
    @(negedge ulpi_clk);
  endtask

  task automatic phy_receive(input ulpi_pkg::byte_t b_q[$], input logic ready);
    @(posedge ulpi_clk);
    rx_ready_i <= ready;
    ulpi_dir_i <= 1'b1;
    ulpi_nxt_i <= 1'b1;
    rx_seen_q.delete();
    last_seen_q.delete();
    stp_seen = 1'b0;
    foreach (b_q[i]) begin
      @(posedge ulpi_clk);
      ulpi_data_i <= b_q[i];
    end
    @(posedge ulpi_clk);
    ulpi_dir_i <= 1'b0;
    ulpi_nxt_i <= 1'b0;
    ulpi_data_i <= 8'h00;
    while (rx_seen_q.size() < b_q.size()) @(negedge ulpi_clk);
    foreach (b_q[i]) begin
      check("rx_data_o", rx_seen_q[i], b_q[i]);
      check("rx_last_o", last_seen_q[i], i == b_q.size() - 1);
    end
    repeat (2) @(negedge ulpi_clk);
    check("rx_valid_o beats", rx_seen_q.size(), b_q.size());
    check("rx_overflow_o", rx_overflow_o, !ready);
    check("ulpi_stp_o with dir high", stp_seen, !ready);
    @(posedge ulpi_clk);
    rx_ready_i <= 1'b1;
    @(negedge ulpi_clk);
  endtask

  initial begin
    int              fd;
    int              code;
    int              v[6];
    string           tok;
    string           line;
    logic            ovf_exp;
    ulpi_pkg::byte_t a_q[$];
    ulpi_pkg::byte_t b_q[$];
    ovf_exp = 1'b0;
    rst_n = 1'b0;
    ulpi_data_i = 8'h00;
    ulpi_dir_i = 1'b0;
    ulpi_nxt_i = 1'b0;
    rx_ready_i = 1'b1;
    tx_valid_i = 1'b0;
    tx_last_i = 1'b0;
    tx_data_i = 8'h00;
    fd = $fopen("verification/ulpi_link_stim.txt", "r");
    if (fd == 0) begin
      reported = 1'b1;
      $display("Could not open the stimulus file");
      $display("Test failures found");
      $fatal(1, "No stimulus");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        code = $fgets(line, fd);
      end else begin
        code = $fscanf(fd, "%h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
        op_q.push_back(tok);
        foreach (v[j]) arg_q.push_back(v[j]);
        limit += 40 + ((tok == "H") ? v[1] : (tok == "R") ? 0 : 8 * v[0]);
      end
    end
    $fclose(fd);
    limit += 100;  // Reset and power-on
    repeat (2) @(posedge ulpi_clk);
    rst_n <= 1'b1;
    for (int k = 0; k < op_q.size(); k++) begin
      foreach (v[j]) v[j] = arg_q[6 * k + j];
      a_q.delete();
      b_q.delete();
      for (int j = 0; j < v[0] && j < 5; j++) b_q.push_back(v[j + 1]);
      case (op_q[k])
        "P": begin
          a_q.push_back(8'h84);
          a_q.push_back(8'h45);
          phy_accept(a_q);
        end
        "R": begin
          send_rxcmd(v[0]);
          check("vbus_valid_o", vbus_valid_o, v[1]);
          check("squelch_o", squelch_o, v[2]);
          check("eop_o", eop_o, v[3]);
        end
        "D", "B": begin
          phy_receive(b_q, op_q[k] == "D");
          if (op_q[k] == "B") ovf_exp = 1'b1;
        end
        "T": begin
          a_q = b_q;
          a_q[0] = 8'h40 | (b_q[0] & 8'h0f);  // TX CMD carries the PID
          @(posedge ulpi_clk);
          fork
            stream_send(b_q);
            phy_accept(a_q);
          join
        end
        "H": begin
          send_rxcmd(v[0]);
          repeat (v[1]) @(negedge ulpi_clk);
          check("usb_reset_o", usb_reset_o, v[2]);
          check("usb_suspend_o", usb_suspend_o, v[3]);
          check("usb_idle_o", usb_idle_o, v[4]);
        end
        default: begin
          reported = 1'b1;
          $display("Unknown operation %s in the stimulus file", op_q[k]);
          $display("Test failures found");
          $fatal(1, "Bad stimulus");
        end
      endcase
    end
    check("rx_overflow_o", rx_overflow_o, ovf_exp);  // Sticky once set
    done = 1'b1;
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Run stopped by an assertion
  final begin
    if (!done && !reported) $display("Test failures found");
  end

endmodule

// File: verification/ulpi_link_chk.sv
`timescale 1ns/1ps

module ulpi_link_chk (
  input logic            ulpi_clk,
  input logic            rst_n,
  input logic            ulpi_dir_i,
  input ulpi_pkg::byte_t link_data_i,
  input logic            stp_i,
  input logic            stop_req_i,
  input logic            rx_valid_i,
  input logic            rx_last_i
);

  // Link releases the bus while the PHY drives it
  bus_released: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    ulpi_dir_i |-> link_data_i == 8'h00)
    else $error("ulpi_data_o not zero while dir is high");

  stp_single: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    stp_i && !$past(stop_req_i) |=> !stp_i)
    else $error("ulpi_stp_o longer than one cycle outside an RX stop");

  last_valid: assert property (@(posedge ulpi_clk) disable iff (!rst_n)
    rx_last_i |-> rx_valid_i)
    else $error("rx_last_o without rx_valid_o");

endmodule

// File: hw/ulpi_link_top.sv
`timescale 1ns/1ps

module ulpi_link_top (
  input  logic            ulpi_clk,
  input  logic            rst_n,
  input  ulpi_pkg::byte_t ulpi_data_i,
  output ulpi_pkg::byte_t ulpi_data_o,
  input  logic            ulpi_dir_i,
  input  logic            ulpi_nxt_i,
  output logic            ulpi_stp_o,
  output logic            rx_valid_o,
  input  logic            rx_ready_i,
  output logic            rx_last_o,
  output ulpi_pkg::byte_t rx_data_o,
  input  logic            tx_valid_i,
  output logic            tx_ready_o,
  input  logic            tx_last_i,
  input  ulpi_pkg::byte_t tx_data_i,
  output logic            rx_overflow_o,
  output logic            vbus_valid_o,
  output logic            squelch_o,
  output logic            eop_o,
  output logic            usb_reset_o,
  output logic            usb_idle_o,
  output logic            usb_suspend_o
);

  logic                  dir_q;
  ulpi_pkg::line_state_t line_state;
  ulpi_pkg::timer_t      line_timer;
  logic                  rx_stop_req;
  logic                  tx_open;
  logic                  tx_take;
  logic                  head_valid;
  logic                  head_last;
  ulpi_pkg::byte_t       head_data;

  ulpi_rxcmd_decode u_rxcmd_decode (
    .ulpi_clk(ulpi_clk), .rst_n(rst_n), .ulpi_dir_i(ulpi_dir_i), .dir_q_i(dir_q),
    .ulpi_nxt_i(ulpi_nxt_i), .ulpi_data_i(ulpi_data_i), .line_state_o(line_state),
    .line_timer_o(line_timer), .vbus_valid_o(vbus_valid_o), .squelch_o(squelch_o),
    .eop_o(eop_o)
  );

  ulpi_rx_capture u_rx_capture (
    .ulpi_clk(ulpi_clk), .rst_n(rst_n), .ulpi_dir_i(ulpi_dir_i), .dir_q_i(dir_q),
    .ulpi_nxt_i(ulpi_nxt_i), .ulpi_data_i(ulpi_data_i), .rx_ready_i(rx_ready_i),
    .rx_valid_o(rx_valid_o), .rx_last_o(rx_last_o), .rx_data_o(rx_data_o),
    .rx_overflow_o(rx_overflow_o), .rx_stop_req_o(rx_stop_req)
  );

  ulpi_tx_buffer u_tx_buffer (
    .ulpi_clk(ulpi_clk), .rst_n(rst_n), .tx_valid_i(tx_valid_i), .tx_last_i(tx_last_i),
    .tx_data_i(tx_data_i), .tx_open_i(tx_open), .tx_take_i(tx_take),
    .tx_ready_o(tx_ready_o), .head_valid_o(head_valid), .head_last_o(head_last),
    .head_data_o(head_data)
  );

  ulpi_link_fsm u_link_fsm (
    .ulpi_clk(ulpi_clk), .rst_n(rst_n), .ulpi_dir_i(ulpi_dir_i), .ulpi_nxt_i(ulpi_nxt_i),
    .line_state_i(line_state), .line_timer_i(line_timer), .head_valid_i(head_valid),
    .head_last_i(head_last), .head_data_i(head_data), .rx_stop_req_i(rx_stop_req),
    .dir_q_o(dir_q), .ulpi_data_o(ulpi_data_o), .ulpi_stp_o(ulpi_stp_o),
    .tx_open_o(tx_open), .tx_take_o(tx_take), .usb_reset_o(usb_reset_o),
    .usb_idle_o(usb_idle_o), .usb_suspend_o(usb_suspend_o)
  );

endmodule

// File: hw/ulpi_link_fsm.sv
`timescale 1ns/1ps

module ulpi_link_fsm (
  input  logic                  ulpi_clk,
  input  logic                  rst_n,
  input  logic                  ulpi_dir_i,
  input  logic                  ulpi_nxt_i,
  input  ulpi_pkg::line_state_t line_state_i,
  input  ulpi_pkg::timer_t      line_timer_i,
  input  logic                  head_valid_i,
  input  logic                  head_last_i,
  input  ulpi_pkg::byte_t       head_data_i,
  input  logic                  rx_stop_req_i,
  output logic                  dir_q_o,
  output ulpi_pkg::byte_t       ulpi_data_o,
  output logic                  ulpi_stp_o,
  output logic                  tx_open_o,
  output logic                  tx_take_o,
  output logic                  usb_reset_o,
  output logic                  usb_idle_o,
  output logic                  usb_suspend_o
);

  ulpi_pkg::link_state_e state_q;
  logic                  dir_q;
  logic                  stp_q;
  ulpi_pkg::byte_t       data_q;
  logic                  reset_q;
  logic                  driving;
  logic                  reset_trip;
  logic                  suspend_trip;
  logic                  start_tx;
  logic                  next_byte;

  // First cycle out of reset counts as turnaround
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) dir_q <= 1'b1;
    else dir_q <= ulpi_dir_i;
  end

  assign driving = !dir_q && !ulpi_dir_i;

  assign reset_trip = line_state_i == ulpi_pkg::LS_SE0 &&
                      line_timer_i > ulpi_pkg::RESET_TIME;
  assign suspend_trip = line_state_i == ulpi_pkg::LS_J &&
                        line_timer_i > ulpi_pkg::SUSPEND_TIME;

  assign start_tx = driving && state_q == ulpi_pkg::IDLE && !reset_trip &&
                    !suspend_trip && head_valid_i;
  assign next_byte = driving && state_q == ulpi_pkg::TX && ulpi_nxt_i && head_valid_i;

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      state_q <= ulpi_pkg::POWER_ON;
      data_q <= '0;
    end else if (driving) begin
      case (state_q)
        ulpi_pkg::POWER_ON: begin
          data_q <= ulpi_pkg::REG_WRITE_FUNC_CTRL;
          state_q <= ulpi_pkg::WRITE_REGA;
        end
        ulpi_pkg::WRITE_REGA: begin
          if (ulpi_nxt_i) begin
            data_q <= ulpi_pkg::FUNC_CTRL_FS;
            state_q <= ulpi_pkg::WRITE_REGD;
          end
        end
        ulpi_pkg::WRITE_REGD: begin
          if (ulpi_nxt_i) begin
            data_q <= '0;
            state_q <= ulpi_pkg::STP;
          end
        end
        ulpi_pkg::STP: state_q <= ulpi_pkg::IDLE;
        ulpi_pkg::IDLE: begin
          if (reset_trip) begin
            state_q <= ulpi_pkg::RESET;
          end else if (suspend_trip) begin
            state_q <= ulpi_pkg::SUSPEND;
          end else if (start_tx) begin
            data_q <= {ulpi_pkg::TXCMD_TRANSMIT, head_data_i[3:0]};  // PID in low nibble
            state_q <= head_last_i ? ulpi_pkg::TX_LAST : ulpi_pkg::TX;
          end
        end
        ulpi_pkg::TX: begin
          if (next_byte) begin
            data_q <= head_data_i;
            state_q <= head_last_i ? ulpi_pkg::TX_LAST : ulpi_pkg::TX;
          end else if (ulpi_nxt_i) begin
            data_q <= '0;  // Source underrun
          end
        end
        ulpi_pkg::TX_LAST: begin
          if (ulpi_nxt_i) begin
            data_q <= '0;
            state_q <= ulpi_pkg::STP;
          end
        end
        ulpi_pkg::RESET: begin
          if (line_state_i != ulpi_pkg::LS_SE0) state_q <= ulpi_pkg::IDLE;
        end
        ulpi_pkg::SUSPEND: begin
          if (line_state_i != ulpi_pkg::LS_J) state_q <= ulpi_pkg::IDLE;
        end
        default: state_q <= ulpi_pkg::POWER_ON;
      endcase
    end
  end

  // STP after the final accepted byte, or to halt a stalled receive
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      stp_q <= 1'b0;
    end else if (driving) begin
      case (state_q)
        ulpi_pkg::WRITE_REGD,
        ulpi_pkg::TX_LAST: stp_q <= ulpi_nxt_i;
        default: stp_q <= 1'b0;
      endcase
    end else begin
      stp_q <= rx_stop_req_i;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) reset_q <= 1'b0;
    else if (state_q == ulpi_pkg::RESET) reset_q <= 1'b1;
    else if (state_q == ulpi_pkg::IDLE) reset_q <= 1'b0;
  end

  assign dir_q_o = dir_q;
  assign ulpi_data_o = driving ? data_q : '0;  // Bus released while PHY drives
  assign ulpi_stp_o = stp_q;
  assign tx_open_o = state_q == ulpi_pkg::IDLE || state_q == ulpi_pkg::TX;
  assign tx_take_o = start_tx || next_byte;
  assign usb_reset_o = reset_q;
  assign usb_idle_o = state_q == ulpi_pkg::IDLE;
  assign usb_suspend_o = state_q == ulpi_pkg::SUSPEND;

endmodule

// File: hw/ulpi_tx_buffer.sv
`timescale 1ns/1ps

module ulpi_tx_buffer (
  input  logic            ulpi_clk,
  input  logic            rst_n,
  input  logic            tx_valid_i,
  input  logic            tx_last_i,
  input  ulpi_pkg::byte_t tx_data_i,
  input  logic            tx_open_i,
  input  logic            tx_take_i,
  output logic            tx_ready_o,
  output logic            head_valid_o,
  output logic            head_last_o,
  output ulpi_pkg::byte_t head_data_o
);

  logic            buf_valid_q;
  logic            buf_last_q;
  ulpi_pkg::byte_t buf_data_q;
  logic            push;
  logic            load;

  // Nothing follows a buffered last byte until the FSM is open again
  assign tx_ready_o = tx_open_i && (!buf_valid_q || (tx_take_i && !buf_last_q));
  assign push = tx_valid_i && tx_ready_o;

  // An empty buffer with a take passes the stream byte straight through
  assign load = push && (buf_valid_q || !tx_take_i);

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      buf_valid_q <= 1'b0;
    end else if (load) begin
      buf_valid_q <= 1'b1;
    end else if (tx_take_i) begin
      buf_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (load) begin
      buf_last_q <= tx_last_i;
      buf_data_q <= tx_data_i;
    end
  end

  // Head falls back to the stream itself when empty
  assign head_valid_o = buf_valid_q || tx_valid_i;
  assign head_last_o = buf_valid_q ? buf_last_q : tx_last_i;
  assign head_data_o = buf_valid_q ? buf_data_q : tx_data_i;

endmodule

// File: hw/ulpi_rx_capture.sv
`timescale 1ns/1ps

module ulpi_rx_capture (
  input  logic            ulpi_clk,
  input  logic            rst_n,
  input  logic            ulpi_dir_i,
  input  logic            dir_q_i,
  input  logic            ulpi_nxt_i,
  input  ulpi_pkg::byte_t ulpi_data_i,
  input  logic            rx_ready_i,
  output logic            rx_valid_o,
  output logic            rx_last_o,
  output ulpi_pkg::byte_t rx_data_o,
  output logic            rx_overflow_o,
  output logic            rx_stop_req_o
);

  logic            rx_byte;
  logic            rx_end;
  logic            cyc_q;   // A byte of the current packet is held
  ulpi_pkg::byte_t hold_q;
  logic            valid_q;
  logic            last_q;
  ulpi_pkg::byte_t data_q;
  logic            ovf_q;

  assign rx_byte = dir_q_i && ulpi_dir_i && ulpi_nxt_i;

  // RxActive dropped in an RX CMD, or the PHY released the bus
  assign rx_end = cyc_q && dir_q_i &&
                  (!ulpi_dir_i || ulpi_data_i[5:4] != ulpi_pkg::RX_ACTIVE);

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      cyc_q <= 1'b0;
      valid_q <= 1'b0;
      last_q <= 1'b0;
    end else if (rx_byte) begin
      cyc_q <= 1'b1;
      valid_q <= cyc_q;  // First byte stays held
      last_q <= 1'b0;
    end else if (rx_end) begin
      cyc_q <= 1'b0;
      valid_q <= 1'b1;
      last_q <= 1'b1;
    end else begin
      valid_q <= 1'b0;
      last_q <= 1'b0;
    end
  end

  always_ff @(posedge ulpi_clk) begin
    if (rx_byte) hold_q <= ulpi_data_i;
    if (rx_byte || rx_end) data_q <= hold_q;
  end

  // Sticky until reset
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) ovf_q <= 1'b0;
    else if (valid_q && !rx_ready_i) ovf_q <= 1'b1;
  end

  assign rx_stop_req_o = dir_q_i && ulpi_dir_i && !rx_ready_i;
  assign rx_valid_o = valid_q;
  assign rx_last_o = last_q;
  assign rx_data_o = data_q;
  assign rx_overflow_o = ovf_q;

endmodule

// File: hw/ulpi_rxcmd_decode.sv
`timescale 1ns/1ps

module ulpi_rxcmd_decode (
  input  logic                  ulpi_clk,
  input  logic                  rst_n,
  input  logic                  ulpi_dir_i,
  input  logic                  dir_q_i,
  input  logic                  ulpi_nxt_i,
  input  ulpi_pkg::byte_t       ulpi_data_i,
  output ulpi_pkg::line_state_t line_state_o,
  output ulpi_pkg::timer_t      line_timer_o,
  output logic                  vbus_valid_o,
  output logic                  squelch_o,
  output logic                  eop_o
);

  logic                  rx_cmd;
  ulpi_pkg::line_state_t new_state;
  ulpi_pkg::line_state_t line_state_q;
  ulpi_pkg::timer_t      timer_q;
  logic                  vbus_q;
  logic                  squelch_q;
  logic                  eop_q;

  // PHY owns the bus and this is not a turnaround
  assign rx_cmd = dir_q_i && ulpi_dir_i && !ulpi_nxt_i;
  assign new_state = ulpi_data_i[1:0];

  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      line_state_q <= ulpi_pkg::LS_K;  // Neither reset nor suspend pending
      vbus_q <= 1'b0;
      squelch_q <= 1'b0;
      eop_q <= 1'b0;
    end else begin
      eop_q <= 1'b0;
      if (rx_cmd) begin
        line_state_q <= new_state;
        vbus_q <= ulpi_data_i[3:2] == ulpi_pkg::VBUS_VALID;
        squelch_q <= new_state == ulpi_pkg::LS_SE0;
        eop_q <= !squelch_q && new_state == ulpi_pkg::LS_SE0;  // Entry into squelch
      end
    end
  end

  // Cycles since the last line-state change
  always_ff @(posedge ulpi_clk) begin
    if (!rst_n) begin
      timer_q <= '0;
    end else if (rx_cmd && new_state != line_state_q) begin
      timer_q <= '0;
    end else if (timer_q != '1) begin
      timer_q <= timer_q + ulpi_pkg::timer_t'(1);
    end
  end

  assign line_state_o = line_state_q;
  assign line_timer_o = timer_q;
  assign vbus_valid_o = vbus_q;
  assign squelch_o = squelch_q;
  assign eop_o = eop_q;

endmodule

// File: hw/ulpi_pkg.sv
package ulpi_pkg;

  typedef logic [7:0] byte_t;        // ULPI bus or stream byte
  typedef logic [1:0] line_state_t;
  typedef logic [7:0] timer_t;       // Saturating line-state timer

  typedef enum logic [3:0] {
    POWER_ON,
    WRITE_REGA,
    WRITE_REGD,
    STP,
    IDLE,
    TX,
    TX_LAST,
    RESET,
    SUSPEND
  } link_state_e;

  // USB line states as reported in RX CMD bits 1:0
  localparam line_state_t LS_SE0 = 2'b00;
  localparam line_state_t LS_J = 2'b01;
  localparam line_state_t LS_K = 2'b10;

  // RX CMD fields
  localparam logic [1:0] RX_ACTIVE = 2'b01;   // Bits 5:4 while a packet is received
  localparam logic [1:0] VBUS_VALID = 2'b11;  // Bits 3:2

  localparam logic [3:0] TXCMD_TRANSMIT = 4'b0100;

  // Power-on register write
  localparam byte_t REG_WRITE_FUNC_CTRL = 8'h84;
  localparam byte_t FUNC_CTRL_FS = 8'h45;  // FS transceiver and termination

  // Scaled down for short simulations
  localparam timer_t RESET_TIME = 8'd40;
  localparam timer_t SUSPEND_TIME = 8'd60;

endpackage
